/* prefetch_fifo_pkg.sv */
//////////////////////////////
// prefetch fifo package
// word and address widths, depth, capacity
// and the occupancy encoding of the
// prefetch state machine
//////////////////////////////

package prefetch_fifo_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  localparam int DATA_W   = 32;              // fifo word width
  localparam int ADDR_W   = 6;               // memory address width
  localparam int DEPTH    = 1 << ADDR_W;     // memory words
  localparam int LEVEL_W  = ADDR_W + 1;      // stored-word counter, holds 0..DEPTH

  // memory plus the two output registers once prefetch settles
  localparam int CAPACITY = DEPTH + 2;

  //////////////////////////////
  // occupancy of output side
  //////////////////////////////

  // words held in the output fifo plus reads still in flight
  typedef enum logic [1:0]
  {
    OCC_NONE = 2'd0,                         // nothing committed
    OCC_ONE  = 2'd1,                         // one word committed
    OCC_TWO  = 2'd2                          // output side full
  } occ_t;

endpackage

/* fifo_sdpram.sv */
//////////////////////////////
// fifo memory
// simple dual-port ram, one write port and
// one clock-enabled registered read port
//////////////////////////////

`timescale 1ns/1ps

module fifo_sdpram
(
  input  logic                                  rd_clk,   // single fifo clock
  input  logic                                  wr_en,    // accepted write
  input  logic [prefetch_fifo_pkg::ADDR_W-1:0]  wr_addr,  // write pointer
  input  logic [prefetch_fifo_pkg::DATA_W-1:0]  wr_data,  // word to store
  input  logic                                  rd_en,    // read clock enable
  input  logic [prefetch_fifo_pkg::ADDR_W-1:0]  rd_addr,  // read pointer
  output logic [prefetch_fifo_pkg::DATA_W-1:0]  rd_q      // registered read data
);

  //////////////////////////////
  // storage
  //////////////////////////////

  logic [prefetch_fifo_pkg::DATA_W-1:0] mem [prefetch_fifo_pkg::DEPTH]; // block ram array

  // write port
  always_ff @(posedge rd_clk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;               // lands at this edge
    end
  end

  // read port, word on rd_q one edge after rd_en
  always_ff @(posedge rd_clk)
  begin
    if (rd_en)
    begin
      rd_q <= mem[rd_addr];                  // holds when not enabled
    end
  end

  // read never hits the address being written, the counter
  // only lets a word out after it is stored

endmodule

/* fifo_ptr_ctrl.sv */
//////////////////////////////
// fifo pointer control
// write and read pointers, stored-word count,
// registered full and empty flags
//////////////////////////////

`timescale 1ns/1ps

module fifo_ptr_ctrl
(
  input  logic                                  rd_clk,   // fifo clock
  input  logic                                  rd_rst,   // async reset, active high
  input  logic                                  push,     // word written to memory
  input  logic                                  pop,      // word read from memory
  output logic [prefetch_fifo_pkg::ADDR_W-1:0]  wr_addr,  // memory write address
  output logic [prefetch_fifo_pkg::ADDR_W-1:0]  rd_addr,  // memory read address
  output logic                                  full,     // memory holds DEPTH words
  output logic                                  empty     // memory holds no word
);

  logic [prefetch_fifo_pkg::ADDR_W-1:0]  wr_ptr;       // next slot to write
  logic [prefetch_fifo_pkg::ADDR_W-1:0]  rd_ptr;       // next slot to read
  logic [prefetch_fifo_pkg::LEVEL_W-1:0] level;        // words stored
  logic [prefetch_fifo_pkg::LEVEL_W-1:0] level_nxt;    // count after this edge

  //////////////////////////////
  // pointers
  //////////////////////////////

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;             // wraps at DEPTH
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assign wr_addr = wr_ptr;
  assign rd_addr = rd_ptr;

  //////////////////////////////
  // level and flags
  //////////////////////////////

  always_comb
  begin
    case ({push, pop})
      2'b10:   level_nxt = level + 1'b1;     // push only
      2'b01:   level_nxt = level - 1'b1;     // pop only
      default: level_nxt = level;            // both or neither
    endcase
  end

  // flags registered from the next level, valid right after the edge
  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      level <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
    end
    else
    begin
      level <= level_nxt;
      full  <= (level_nxt == prefetch_fifo_pkg::LEVEL_W'(prefetch_fifo_pkg::DEPTH));
      empty <= (level_nxt == '0);
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // writer must respect wr_vld
  a_no_overflow : assert property (@(posedge rd_clk) disable iff (rd_rst)
    push |-> !full);

  // prefetch must respect empty
  a_no_underflow : assert property (@(posedge rd_clk) disable iff (rd_rst)
    pop |-> !empty);

endmodule

/* prefetch_fsm.sv */
//////////////////////////////
// prefetch state machine
// reads memory ahead of the reader so the
// output fifo stays loaded, tracks words
// committed to the output side
//////////////////////////////

`timescale 1ns/1ps

module prefetch_fsm
(
  input  logic rd_clk,                       // fifo clock
  input  logic rd_rst,                       // async reset, active high
  input  logic empty,                        // memory has no stored word
  input  logic pop,                          // reader took a word
  output logic mem_rd,                       // issue one memory read
  output logic land                          // mem_q valid this cycle
);

  prefetch_fifo_pkg::occ_t occ;              // committed words
  prefetch_fifo_pkg::occ_t occ_nxt;

  //////////////////////////////
  // read issue
  //////////////////////////////

  // room below two, or a slot freed by a pop this cycle
  assign mem_rd = !empty &&
                  ((occ != prefetch_fifo_pkg::OCC_TWO) || pop);

  //////////////////////////////
  // occupancy
  //////////////////////////////

  always_comb
  begin
    occ_nxt = occ;                           // hold on both or neither
    case ({mem_rd, pop})
      2'b10:
      begin
        case (occ)                           // read alone, one more committed
          prefetch_fifo_pkg::OCC_NONE: occ_nxt = prefetch_fifo_pkg::OCC_ONE;
          prefetch_fifo_pkg::OCC_ONE:  occ_nxt = prefetch_fifo_pkg::OCC_TWO;
          default:                     occ_nxt = occ;
        endcase
      end
      2'b01:
      begin
        case (occ)                           // pop alone, one slot freed
          prefetch_fifo_pkg::OCC_TWO:  occ_nxt = prefetch_fifo_pkg::OCC_ONE;
          prefetch_fifo_pkg::OCC_ONE:  occ_nxt = prefetch_fifo_pkg::OCC_NONE;
          default:                     occ_nxt = occ;
        endcase
      end
      default: occ_nxt = occ;
    endcase
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      occ  <= prefetch_fifo_pkg::OCC_NONE;
      land <= 1'b0;
    end
    else
    begin
      occ  <= occ_nxt;
      land <= mem_rd;                        // ram read latency of one
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // output fifo shows a word only when one was committed
  a_no_pop_none : assert property (@(posedge rd_clk) disable iff (rd_rst)
    pop |-> (occ != prefetch_fifo_pkg::OCC_NONE));

endmodule

/* out_reg_fifo.sv */
//////////////////////////////
// output register fifo
// two registered entries in front of the
// memory, drives rd_data and rd_vld
//////////////////////////////

`timescale 1ns/1ps

module out_reg_fifo
(
  input  logic                                  rd_clk,   // fifo clock
  input  logic                                  rd_rst,   // async reset, active high
  input  logic                                  land,     // din holds a valid word
  input  logic [prefetch_fifo_pkg::DATA_W-1:0]  din,      // memory read data
  input  logic                                  rd_en,    // reader wants a word
  output logic                                  pop,      // word taken this cycle
  output logic [prefetch_fifo_pkg::DATA_W-1:0]  rd_data,  // oldest word
  output logic                                  rd_vld    // a word is waiting
);

  logic [prefetch_fifo_pkg::DATA_W-1:0] entry [2];  // payload, no reset
  logic                                 head;       // oldest entry
  logic [1:0]                           count;      // words held, 0..2
  logic                                 tail;       // slot for next landing word

  assign pop     = rd_en && rd_vld;
  assign rd_vld  = (count != 2'd0);
  assign rd_data = entry[head];

  // count of two lands only with a pop, so tail reuses the freed head
  assign tail    = head ^ count[0];

  //////////////////////////////
  // data
  //////////////////////////////

  always_ff @(posedge rd_clk)
  begin
    if (land)
    begin
      entry[tail] <= din;                    // head slot untouched while held
    end
  end

  //////////////////////////////
  // head and count
  //////////////////////////////

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      head  <= 1'b0;
      count <= 2'd0;
    end
    else
    begin
      if (pop)
        head <= ~head;                       // next entry becomes oldest
      case ({land, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;             // land and pop cancel
      endcase
    end
  end

  // fsm caps committed words at OCC_TWO, so a full buffer never takes a word
  a_no_land_full : assert property (@(posedge rd_clk) disable iff (rd_rst)
    land |-> ((count != 2'(prefetch_fifo_pkg::OCC_TWO)) || pop));

endmodule

/* prefetch_fifo.sv */
//////////////////////////////
// prefetch fifo top
// first-word-fall-through fifo, memory plus
// prefetch into a two-entry output fifo
//////////////////////////////

`timescale 1ns/1ps

module prefetch_fifo
(
  input  logic                                  rd_clk,   // fifo clock
  input  logic                                  rd_rst,   // async reset, active high
  input  logic [prefetch_fifo_pkg::DATA_W-1:0]  wr_data,  // write word
  input  logic                                  wr_en,    // write request
  output logic                                  wr_vld,   // fifo can take a word
  output logic [prefetch_fifo_pkg::DATA_W-1:0]  rd_data,  // oldest word
  input  logic                                  rd_en,    // read request
  output logic                                  rd_vld    // rd_data is valid
);

  logic [prefetch_fifo_pkg::ADDR_W-1:0] wr_addr;  // memory write pointer
  logic [prefetch_fifo_pkg::ADDR_W-1:0] rd_addr;  // memory read pointer
  logic [prefetch_fifo_pkg::DATA_W-1:0] mem_q;    // registered ram output
  logic                                 full;
  logic                                 empty;
  logic                                 wr_push;  // accepted write
  logic                                 mem_rd;   // prefetch read
  logic                                 land;     // mem_q valid
  logic                                 pop;      // reader took a word

  //////////////////////////////
  // write side
  //////////////////////////////

  assign wr_vld  = ~full;
  assign wr_push = wr_en & wr_vld;           // writes while full are dropped

  fifo_sdpram fifo_sdpram_inst
  (
    .rd_clk  (rd_clk),
    .wr_en   (wr_push),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (mem_rd),
    .rd_addr (rd_addr),
    .rd_q    (mem_q)
  );

  fifo_ptr_ctrl fifo_ptr_ctrl_inst
  (
    .rd_clk  (rd_clk),
    .rd_rst  (rd_rst),
    .push    (wr_push),
    .pop     (mem_rd),                       // prefetch drains the memory
    .wr_addr (wr_addr),
    .rd_addr (rd_addr),
    .full    (full),
    .empty   (empty)
  );

  //////////////////////////////
  // read side
  //////////////////////////////

  prefetch_fsm prefetch_fsm_inst
  (
    .rd_clk  (rd_clk),
    .rd_rst  (rd_rst),
    .empty   (empty),
    .pop     (pop),
    .mem_rd  (mem_rd),
    .land    (land)
  );

  out_reg_fifo out_reg_fifo_inst
  (
    .rd_clk  (rd_clk),
    .rd_rst  (rd_rst),
    .land    (land),
    .din     (mem_q),
    .rd_en   (rd_en),
    .pop     (pop),
    .rd_data (rd_data),
    .rd_vld  (rd_vld)
  );

endmodule

/* prefetch_fifo_tb.sv */
//////////////////////////////
// prefetch fifo testbench
// reset, latency, capacity, hold,
// streaming and random traffic against
// a queue model of the fifo
//////////////////////////////

`timescale 1ns/1ps

module prefetch_fifo_tb;

  localparam int RST_CYCLES    = 8;
  localparam int STREAM_CYCLES = 64;
  localparam int RAND_CYCLES   = 4000;
  localparam int FILL_CYCLES   = prefetch_fifo_pkg::CAPACITY + 20;  // fill, hold, flags
  localparam int DRAIN_CYCLES  = prefetch_fifo_pkg::CAPACITY + 16;  // one drain, worst case
  localparam int TEST_CYCLES   = RST_CYCLES + 16 + FILL_CYCLES + STREAM_CYCLES + 16 +
                                 RAND_CYCLES + 4 * DRAIN_CYCLES;
  localparam int LIMIT_CYCLES  = TEST_CYCLES + TEST_CYCLES / 4 + 200;  // plus margin

  logic                                 rd_clk;
  logic                                 rd_rst;
  logic [prefetch_fifo_pkg::DATA_W-1:0] wr_data;
  logic                                 wr_en;
  logic                                 wr_vld;
  logic [prefetch_fifo_pkg::DATA_W-1:0] rd_data;
  logic                                 rd_en;
  logic                                 rd_vld;

  logic [prefetch_fifo_pkg::DATA_W-1:0] model_q [$];  // words written, not yet read
  integer                               seed = 32'hf4eef317;
  int                                   err_count = 0;
  int                                   checked = 0;    // popped words compared
  string                                test_name = "none";

  prefetch_fifo prefetch_fifo_inst
  (
    .rd_clk  (rd_clk),
    .rd_rst  (rd_rst),
    .wr_data (wr_data),
    .wr_en   (wr_en),
    .wr_vld  (wr_vld),
    .rd_data (rd_data),
    .rd_en   (rd_en),
    .rd_vld  (rd_vld)
  );

  initial
  begin
    rd_clk = 1'b0;
    forever #2 rd_clk = ~rd_clk;             // 4 ns period
  end

  //////////////////////////////
  // model and compare
  //////////////////////////////

  // fifo order, oldest written word is the next one out
  function automatic logic [31:0] model_pop();
    logic [31:0] word;
    word = model_q.pop_front();
    return word;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  // inputs and outputs are all settled at the falling edge
  always @(negedge rd_clk)
  begin
    if (!rd_rst)
    begin
      if (rd_en && rd_vld)                   // pop at the coming edge
      begin
        assert (model_q.size() != 0)
        else
        begin
          $display("%s: fifo offered a word that was never written", test_name);
          err_count++;
        end
        if (model_q.size() != 0)
        begin
          compare_word(test_name, model_pop(), rd_data);
          checked++;
        end
      end
      if (wr_en && wr_vld)                   // accepted write
        model_q.push_back(wr_data);
      assert (model_q.size() <= prefetch_fifo_pkg::CAPACITY)
      else
      begin
        $display("%s: fifo accepted more words than it can hold", test_name);
        err_count++;
      end
    end
  end

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic drain_fifo();
    @(posedge rd_clk);
    wr_en <= 1'b0;
    rd_en <= 1'b1;
    while (model_q.size() != 0)
      @(posedge rd_clk);
    rd_en <= 1'b0;
    repeat (4) @(negedge rd_clk);
    assert (!rd_vld)
    else
    begin
      $display("%s: fifo still shows a word after draining", test_name);
      err_count++;
    end
  endtask

  task automatic reset_state();
    int i;
    test_name = "reset_state";
    for (i = 0; i < RST_CYCLES; i++)
    begin
      @(negedge rd_clk);
      compare_word(test_name, 32'd0, 32'(rd_vld));
      compare_word(test_name, 32'd1, 32'(wr_vld));
    end
    @(posedge rd_clk);
    rd_rst <= 1'b0;
    repeat (2)
    begin
      @(negedge rd_clk);                     // just after release
      compare_word(test_name, 32'd0, 32'(rd_vld));
      compare_word(test_name, 32'd1, 32'(wr_vld));
    end
  endtask

  task automatic fall_through();
    logic [31:0] word;
    test_name = "fall_through";
    word = 32'h5a0f_c3e1;
    @(posedge rd_clk);
    wr_en   <= 1'b1;
    wr_data <= word;
    @(posedge rd_clk);                       // edge N stores the word
    wr_en <= 1'b0;
    @(negedge rd_clk);
    compare_word(test_name, 32'd0, 32'(rd_vld));  // after N
    @(negedge rd_clk);
    compare_word(test_name, 32'd0, 32'(rd_vld));  // after N+1, word on mem_q
    @(negedge rd_clk);
    compare_word(test_name, 32'd1, 32'(rd_vld));  // after N+2
    compare_word(test_name, word, rd_data);
    drain_fifo();
  endtask

  task automatic fill_and_drain();
    int          i;
    int          accepted;
    logic        seen_full;
    logic [31:0] held;
    test_name = "capacity";
    accepted  = 0;
    seen_full = 1'b0;
    for (i = 0; i < prefetch_fifo_pkg::CAPACITY + 8; i++)
    begin
      @(posedge rd_clk);
      wr_en   <= 1'b1;
      wr_data <= 32'h1000_0000 + 32'(i);
      @(negedge rd_clk);
      if (wr_vld && !seen_full)
        accepted++;
      else if (!wr_vld)
        seen_full = 1'b1;
      else
      begin
        $display("%s: wr_vld rose again with no word read", test_name);
        err_count++;
      end
    end
    @(posedge rd_clk);
    wr_en <= 1'b0;
    compare_word(test_name, 32'(prefetch_fifo_pkg::CAPACITY), 32'(accepted));
    @(negedge rd_clk);
    compare_word(test_name, 32'd0, 32'(wr_vld));
    test_name = "backpressure";
    held = model_q[0];                       // oldest accepted word sits at the head
    repeat (10)
    begin
      @(negedge rd_clk);                     // rd_en low, nothing may move
      compare_word(test_name, 32'd1, 32'(rd_vld));
      compare_word(test_name, held, rd_data);
    end
    test_name = "capacity";
    drain_fifo();
    compare_word(test_name, 32'd1, 32'(wr_vld));
  endtask

  task automatic stream_words();
    int i;
    test_name = "streaming";
    for (i = 0; i < 3; i++)
    begin
      @(posedge rd_clk);
      wr_en   <= 1'b1;
      wr_data <= 32'h2000_0000 + 32'(i);
    end
    @(posedge rd_clk);
    wr_en <= 1'b0;
    repeat (4) @(posedge rd_clk);            // prefetch settles at two words
    for (i = 3; i < STREAM_CYCLES + 3; i++)
    begin
      @(posedge rd_clk);
      rd_en   <= 1'b1;
      wr_en   <= 1'b1;
      wr_data <= 32'h2000_0000 + 32'(i);
      @(negedge rd_clk);
      assert (rd_vld)
      else
      begin
        $display("%s: no word ready on streaming cycle %0d", test_name, i - 3);
        err_count++;
      end
    end
    drain_fifo();
  endtask

  task automatic random_traffic();
    int          i;
    logic [31:0] rnd;
    test_name = "random";
    for (i = 0; i < RAND_CYCLES; i++)
    begin
      @(posedge rd_clk);
      rnd = $random(seed);
      if (i < RAND_CYCLES / 2)
      begin
        wr_en <= rnd[0] | rnd[1];            // write heavy, reaches full
        rd_en <= rnd[2];
      end
      else
      begin
        wr_en <= rnd[0];
        rd_en <= rnd[1] | rnd[2];            // read heavy, reaches empty
      end
      wr_data <= $random(seed);
    end
    drain_fifo();
  endtask

  //////////////////////////////
  // run and watchdog
  //////////////////////////////

  initial
  begin
    rd_rst  = 1'b1;
    wr_en   = 1'b0;
    rd_en   = 1'b0;
    wr_data = '0;
    reset_state();
    fall_through();
    fill_and_drain();
    stream_words();
    random_traffic();
    @(negedge rd_clk);
    $display("errors: %0d, words checked: %0d", err_count, checked);
    if (err_count == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial
  begin
    repeat (LIMIT_CYCLES) @(posedge rd_clk);
    $display("timeout: tests did not finish within %0d cycles", LIMIT_CYCLES);
    $display("errors: %0d, words checked: %0d", err_count, checked);
    $display("Regression failed");
    $finish;
  end

endmodule

/* prefetch_fifo.f */
prefetch_fifo_pkg.sv
fifo_sdpram.sv
fifo_ptr_ctrl.sv
prefetch_fsm.sv
out_reg_fifo.sv
prefetch_fifo.sv
prefetch_fifo_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the prefetch fifo testbench with verilator and runs it
# exit status is zero only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f prefetch_fifo.f --top-module prefetch_fifo_tb -o prefetch_fifo_sim \
  && obj_dir/prefetch_fifo_sim | tee /dev/stderr | grep -q "^Regression passed$" \
  && { echo "simulation ok"; exit 0; } \
  || { echo "simulation not ok"; exit 1; }
